//--- source/isaPkg.sv
package isaPkg;

    typedef enum logic [3:0] {
        opAnd = 4'd0,
        opOr  = 4'd1,
        opNot = 4'd2,
        opAdd = 4'd3,
        opSub = 4'd4,
        opLsr = 4'd5,
        opLsl = 4'd6,
        opInc = 4'd7,
        opDec = 4'd8,
        opBra = 4'd9,
        opBne = 4'd10,
        opMov = 4'd11,
        opLd  = 4'd12,
        opSt  = 4'd13   // 14 and 15 unused
    } opcode_t;

    // Top bit ignored, 0-3 are R1-R4
    typedef struct packed {
        logic       spare;
        logic [2:0] number;
    } regField_t;

    typedef struct packed {
        opcode_t   opcode;
        regField_t destination;
        regField_t source1;
        regField_t source2;
    } registerFormat_t;

    typedef struct packed {
        opcode_t    opcode;
        logic       reserved;
        logic       directMode;  // 1 = direct
        logic [1:0] regSelect;   // R1-R4
        logic [7:0] address;
    } addressFormat_t;

    typedef union packed {
        registerFormat_t registerFormat;
        addressFormat_t  addressFormat;
    } instrWord_t;

    localparam logic [2:0] firstAddressReg = 3'd4;
    localparam logic [2:0] regNumSp = 3'd4;
    localparam logic [2:0] regNumAr = 3'd5;
    localparam logic [2:0] regNumPc = 3'd6;  // 7 also maps to PC

endpackage

//--- source/controlPkg.sv
package controlPkg;

    typedef enum logic [1:0] {
        stepT0 = 2'd0,
        stepT1 = 2'd1,
        stepT2 = 2'd2,
        stepT3 = 2'd3
    } step_t;

    typedef enum logic [1:0] {
        wfLoad      = 2'b01,
        wfDecrement = 2'b10,
        wfIncrement = 2'b11
    } writeFunction_t;

    typedef enum logic [1:0] {
        srcAlu    = 2'd0,
        srcMemory = 2'd1,
        srcIr     = 2'd2   // Low IR byte
    } writeSource_t;

    typedef enum logic [3:0] {
        aluPassA = 4'b0000,
        aluPassB = 4'b0001,
        aluNotA  = 4'b0010,
        aluAdd   = 4'b0100,
        aluSub   = 4'b0101,
        aluAnd   = 4'b0111,
        aluOr    = 4'b1000,
        aluLsl   = 4'b1011,
        aluLsr   = 4'b1100
    } aluFunction_t;

    localparam logic [2:0] rfReadR1 = 3'b100;
    localparam logic [2:0] rfReadR2 = 3'b101;
    localparam logic [2:0] rfReadR3 = 3'b110;
    localparam logic [2:0] rfReadR4 = 3'b111;

    // Address register file read codes, shared by ports C and D
    localparam logic [1:0] arfReadAr = 2'b00;
    localparam logic [1:0] arfReadSp = 2'b01;
    localparam logic [1:0] arfReadPc = 2'b11;

    localparam logic [3:0] regSelPc = 4'b1000;
    localparam logic [3:0] regSelAr = 4'b0100;
    localparam logic [3:0] regSelSp = 4'b0010;

    localparam logic [1:0] muxAAlu    = 2'b00;
    localparam logic [1:0] muxAMemory = 2'b01;
    localparam logic [1:0] muxAIr     = 2'b10;
    localparam logic [1:0] muxAArfOut = 2'b11;

    localparam logic [1:0] muxBAlu    = 2'b00;
    localparam logic [1:0] muxBArfOut = 2'b01;
    localparam logic [1:0] muxBIr     = 2'b10;
    localparam logic [1:0] muxBMemory = 2'b11;

    localparam logic muxCRegFile    = 1'b0;
    localparam logic muxCAddressReg = 1'b1;

    localparam int zeroFlagBit = 3;

endpackage

//--- source/fetchSequencer.sv
`timescale 1ns/1ps

module fetchSequencer (
    input  logic              clock,
    input  logic              reset,
    output controlPkg::step_t step,
    output logic              pcAdvance,
    output logic              IR_Enable,
    output logic              IR_LH
);
    import controlPkg::*;

    logic started;
    logic fetching;

    // First clock after reset only arms the counter, so T0 is a real fetch
    always_ff @(posedge clock) begin
        if (reset) begin
            step <= stepT0;
            started <= 1'b0;
        end else begin
            started <= 1'b1;
            if (started) begin
                step <= step_t'(step + 2'd1);  // Wraps T3 -> T0
            end
        end
    end

    assign fetching = started && (step == stepT0 || step == stepT1);

    assign IR_Enable = fetching;
    assign IR_LH = (step == stepT1);   // Low byte then high byte
    assign pcAdvance = fetching;

endmodule

//--- source/operandSelect.sv
`timescale 1ns/1ps

module operandSelect (
    input  isaPkg::instrWord_t irWord,
    input  logic               readA,
    input  logic               readB,
    input  logic               orderedOperands,
    output logic [2:0]         RF_OutASel,
    output logic [2:0]         RF_OutBSel,
    output logic [1:0]         ARF_OutCSel,
    output logic               MuxCSel
);
    import isaPkg::*;
    import controlPkg::*;

    logic [2:0] source1;
    logic [2:0] source2;
    logic       swap;
    logic [2:0] portA;
    logic [2:0] portB;

    function automatic logic [2:0] rfReadCode(input logic [1:0] index);
        case (index)
            2'd0: return rfReadR1;
            2'd1: return rfReadR2;
            2'd2: return rfReadR3;
            default: return rfReadR4;
        endcase
    endfunction

    assign source1 = irWord.registerFormat.source1.number;
    // ST names its register in the address format
    assign source2 = (irWord.addressFormat.opcode == opSt)
                   ? {1'b0, irWord.addressFormat.regSelect}
                   : irWord.registerFormat.source2.number;

    assign swap = orderedOperands && (source2 > source1);  // Larger number on port A
    assign portA = swap ? source2 : source1;
    assign portB = swap ? source1 : source2;

    always_comb begin
        RF_OutASel = rfReadR1;
        RF_OutBSel = rfReadR1;
        ARF_OutCSel = arfReadPc;
        MuxCSel = muxCRegFile;
        if (readA) begin
            if (portA < firstAddressReg) begin
                RF_OutASel = rfReadCode(portA[1:0]);
            end else begin
                MuxCSel = muxCAddressReg;
                case (portA)
                    regNumSp: ARF_OutCSel = arfReadSp;
                    regNumAr: ARF_OutCSel = arfReadAr;
                    default:  ARF_OutCSel = arfReadPc;
                endcase
            end
        end
        if (readB) begin
            RF_OutBSel = rfReadCode(portB[1:0]);   // R1-R4 only
        end
    end

endmodule

//--- source/executeDecoder.sv
`timescale 1ns/1ps

module executeDecoder (
    input  controlPkg::step_t          step,
    input  isaPkg::instrWord_t         irWord,
    input  logic [3:0]                 aluFlags,
    output logic [3:0]                 ALU_FunSel,
    output logic [1:0]                 ARF_OutDSel,
    output logic                       Mem_WR,
    output logic                       readA,
    output logic                       readB,
    output logic                       orderedOperands,
    output logic                       writeEnable,
    output isaPkg::regField_t          writeTarget,
    output controlPkg::writeFunction_t writeFunction,
    output controlPkg::writeSource_t   writeSource
);
    import isaPkg::*;
    import controlPkg::*;

    opcode_t   opcode;
    regField_t destination;
    regField_t selectedReg;
    regField_t arTarget;
    regField_t pcTarget;
    logic      directMode;
    logic      zeroFlag;
    logic      executing;

    function automatic aluFunction_t aluFunctionFor(input opcode_t op);
        case (op)
            opAnd: return aluAnd;
            opOr:  return aluOr;
            opNot: return aluNotA;
            opAdd: return aluAdd;
            opSub: return aluSub;
            opLsr: return aluLsr;
            opLsl: return aluLsl;
            default: return aluPassA;  // MOV
        endcase
    endfunction

    assign opcode = irWord.registerFormat.opcode;
    assign destination = irWord.registerFormat.destination;
    assign directMode = irWord.addressFormat.directMode;
    assign selectedReg = '{spare: 1'b0, number: {1'b0, irWord.addressFormat.regSelect}};
    assign arTarget = '{spare: 1'b0, number: regNumAr};
    assign pcTarget = '{spare: 1'b0, number: regNumPc};
    assign zeroFlag = aluFlags[zeroFlagBit];
    assign executing = (step == stepT2) || (step == stepT3);

    // Memory address comes from AR only in the last step of LD and ST
    assign ARF_OutDSel = ((opcode == opLd || opcode == opSt) && step == stepT3)
                       ? arfReadAr : arfReadPc;

    always_comb begin
        ALU_FunSel = aluPassA;
        Mem_WR = 1'b0;
        readA = 1'b0;
        readB = 1'b0;
        orderedOperands = 1'b0;
        writeEnable = 1'b0;
        writeTarget = destination;
        writeFunction = wfLoad;
        writeSource = srcAlu;
        if (executing) begin
            case (opcode)
                opAnd, opOr, opNot, opAdd, opSub, opLsr, opLsl, opMov: begin
                    if (step == stepT2) begin
                        readA = 1'b1;
                        readB = opcode inside {opAnd, opOr, opAdd, opSub};
                        orderedOperands = opcode inside {opAnd, opOr, opAdd};
                        ALU_FunSel = aluFunctionFor(opcode);
                        writeEnable = 1'b1;
                    end
                end
                opInc, opDec: begin
                    writeEnable = 1'b1;
                    if (step == stepT2) begin
                        readA = 1'b1;  // Copy source1 first
                    end else begin
                        writeFunction = (opcode == opInc) ? wfIncrement : wfDecrement;
                    end
                end
                opBra, opBne: begin
                    // BNE falls through when Z is set
                    if (step == stepT2 && (opcode == opBra || !zeroFlag)) begin
                        writeEnable = 1'b1;
                        writeTarget = pcTarget;
                        writeSource = srcIr;
                    end
                end
                opLd: begin
                    if (step == stepT2) begin
                        writeEnable = 1'b1;
                        writeTarget = directMode ? arTarget : selectedReg;
                        writeSource = srcIr;
                    end else if (directMode) begin
                        writeEnable = 1'b1;
                        writeTarget = selectedReg;
                        writeSource = srcMemory;
                    end
                end
                opSt: begin
                    if (step == stepT2) begin
                        writeEnable = 1'b1;
                        writeTarget = arTarget;
                        writeSource = srcIr;
                    end else begin
                        readB = 1'b1;
                        ALU_FunSel = aluPassB;
                        Mem_WR = 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- source/writebackSelect.sv
`timescale 1ns/1ps

module writebackSelect (
    input  logic                       pcAdvance,
    input  logic                       writeEnable,
    input  isaPkg::regField_t          writeTarget,
    input  controlPkg::writeFunction_t writeFunction,
    input  controlPkg::writeSource_t   writeSource,
    output logic [3:0]                 RF_RSel,
    output logic [1:0]                 RF_FunSel,
    output logic [3:0]                 ARF_RegSel,
    output logic [1:0]                 ARF_FunSel,
    output logic [1:0]                 MuxASel,
    output logic [1:0]                 MuxBSel
);
    import isaPkg::*;
    import controlPkg::*;

    logic [2:0] targetNumber;

    assign targetNumber = writeTarget.number;

    always_comb begin
        RF_RSel = 4'b0000;
        RF_FunSel = wfLoad;
        ARF_RegSel = 4'b0000;
        ARF_FunSel = wfLoad;
        MuxASel = muxAAlu;
        MuxBSel = muxBAlu;
        if (pcAdvance) begin
            ARF_RegSel = regSelPc;
            ARF_FunSel = wfIncrement;
        end else if (writeEnable) begin
            if (targetNumber < firstAddressReg) begin
                RF_RSel = 4'b1000 >> targetNumber[1:0];  // R1 is the MSB
                RF_FunSel = writeFunction;
                case (writeSource)
                    srcMemory: MuxASel = muxAMemory;
                    srcIr:     MuxASel = muxAIr;
                    default:   MuxASel = muxAAlu;
                endcase
            end else begin
                case (targetNumber)
                    regNumSp: ARF_RegSel = regSelSp;
                    regNumAr: ARF_RegSel = regSelAr;
                    default:  ARF_RegSel = regSelPc;
                endcase
                ARF_FunSel = writeFunction;
                case (writeSource)
                    srcMemory: MuxBSel = muxBMemory;
                    srcIr:     MuxBSel = muxBIr;
                    default:   MuxBSel = muxBAlu;
                endcase
            end
        end
    end

endmodule

//--- source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic               clock,
    input  logic               reset,
    input  isaPkg::instrWord_t irWord,
    input  logic [3:0]         aluFlags,
    output logic [2:0]         RF_OutASel,
    output logic [2:0]         RF_OutBSel,
    output logic [1:0]         RF_FunSel,
    output logic [3:0]         RF_RSel,
    output logic [3:0]         ALU_FunSel,
    output logic [1:0]         ARF_OutCSel,
    output logic [1:0]         ARF_OutDSel,
    output logic [1:0]         ARF_FunSel,
    output logic [3:0]         ARF_RegSel,
    output logic               IR_LH,
    output logic               IR_Enable,
    output logic               Mem_WR,
    output logic [1:0]         MuxASel,
    output logic [1:0]         MuxBSel,
    output logic               MuxCSel
);
    import isaPkg::*;
    import controlPkg::*;

    step_t          step;
    logic           pcAdvance;
    logic           readA;
    logic           readB;
    logic           orderedOperands;
    logic           writeEnable;
    regField_t      writeTarget;
    writeFunction_t writeFunction;
    writeSource_t   writeSource;

    fetchSequencer fetchSequencer_i (
        .clock(clock),
        .reset(reset),
        .step(step),
        .pcAdvance(pcAdvance),
        .IR_Enable(IR_Enable),
        .IR_LH(IR_LH)
    );

    executeDecoder executeDecoder_i (
        .step(step),
        .irWord(irWord),
        .aluFlags(aluFlags),
        .ALU_FunSel(ALU_FunSel),
        .ARF_OutDSel(ARF_OutDSel),
        .Mem_WR(Mem_WR),
        .readA(readA),
        .readB(readB),
        .orderedOperands(orderedOperands),
        .writeEnable(writeEnable),
        .writeTarget(writeTarget),
        .writeFunction(writeFunction),
        .writeSource(writeSource)
    );

    operandSelect operandSelect_i (
        .irWord(irWord),
        .readA(readA),
        .readB(readB),
        .orderedOperands(orderedOperands),
        .RF_OutASel(RF_OutASel),
        .RF_OutBSel(RF_OutBSel),
        .ARF_OutCSel(ARF_OutCSel),
        .MuxCSel(MuxCSel)
    );

    writebackSelect writebackSelect_i (
        .pcAdvance(pcAdvance),
        .writeEnable(writeEnable),
        .writeTarget(writeTarget),
        .writeFunction(writeFunction),
        .writeSource(writeSource),
        .RF_RSel(RF_RSel),
        .RF_FunSel(RF_FunSel),
        .ARF_RegSel(ARF_RegSel),
        .ARF_FunSel(ARF_FunSel),
        .MuxASel(MuxASel),
        .MuxBSel(MuxBSel)
    );

endmodule

//--- verif/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;
    import isaPkg::*;
    import controlPkg::*;

    localparam int instrCount = 200;
    localparam int cycleLimit = 8 + 4 * instrCount + 20;
    localparam int fromAlu = 0;
    localparam int fromMemory = 1;
    localparam int fromIr = 2;
    localparam int anySource = 3;   // INC/DEC count in place

    logic       clock;
    logic       reset;
    instrWord_t irWord;
    logic [3:0] aluFlags;
    logic [2:0] RF_OutASel, RF_OutBSel;
    logic [1:0] RF_FunSel, ARF_OutCSel, ARF_OutDSel, ARF_FunSel, MuxASel, MuxBSel;
    logic [3:0] RF_RSel, ALU_FunSel, ARF_RegSel;
    logic       IR_LH, IR_Enable, Mem_WR, MuxCSel;

    logic [15:0] lfsrState;
    int          edgeCount;
    int          cycleCount;
    logic [1:0]  tbStep;
    opcode_t     op;
    logic [2:0]  dst, src1, src2, regSel, portA, portB;
    logic        inFetch, inT2, inT3, direct, aluOp, binaryOp, incDec;
    logic        branchTaken, noRequest;
    logic [15:0] writeBus;
    logic [8:0]  readBus;

    controlUnit controlUnit_i (.*);

    always #10 clock = ~clock;

    // First edge after reset release starts T0
    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        edgeCount <= reset ? 0 : edgeCount + 1;
        if (cycleCount >= cycleLimit) begin
            stopWithFailure("Timeout: the run went past its cycle limit");
        end
    end

    assign tbStep = 2'(edgeCount - 1);
    assign inFetch = edgeCount > 0 && tbStep < 2'd2;
    assign inT2 = edgeCount > 0 && tbStep == 2'd2;
    assign inT3 = edgeCount > 0 && tbStep == 2'd3;
    assign op = irWord.registerFormat.opcode;
    assign dst = irWord.registerFormat.destination.number;
    assign src1 = irWord.registerFormat.source1.number;
    assign src2 = irWord.registerFormat.source2.number;
    assign regSel = {1'b0, irWord.addressFormat.regSelect};
    assign direct = irWord.addressFormat.directMode;
    assign aluOp = op inside {opAnd, opOr, opNot, opAdd, opSub, opLsr, opLsl, opMov};
    assign binaryOp = op inside {opAnd, opOr, opAdd, opSub};
    assign incDec = op inside {opInc, opDec};
    assign portA = (op inside {opAnd, opOr, opAdd} && src2 > src1) ? src2 : src1;
    assign portB = (portA == src1) ? src2 : src1;
    assign branchTaken = op == opBra || (op == opBne && !aluFlags[3]);  // Z is bit 3
    assign noRequest = (inT3 && (aluOp || op inside {opBra, opBne} || (op == opLd && !direct)))
                     || (inT2 && op == opBne && !branchTaken);
    assign writeBus = {RF_RSel, RF_FunSel, ARF_RegSel, ARF_FunSel, MuxASel, MuxBSel};
    assign readBus = {RF_OutASel, RF_OutBSel, ARF_OutCSel, MuxCSel};

    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic takeBits(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[14:0], lfsrState[0]};
        end
    endtask

    function automatic logic [3:0] expectedAlu(input opcode_t code);
        case (code)
            opAnd: return 4'b0111;
            opOr:  return 4'b1000;
            opNot: return 4'b0010;
            opAdd: return 4'b0100;
            opSub: return 4'b0101;
            opLsr: return 4'b1100;
            opLsl: return 4'b1011;
            default: return 4'b0000;  // MOV passes A
        endcase
    endfunction

    function automatic bit writeOk(input logic [15:0] bus, input logic [2:0] target,
                                   input logic [1:0] fun, input int source);
        logic [1:0] muxAWant;
        logic [1:0] muxBWant;
        logic [3:0] arfWant;
        muxAWant = (source == fromMemory) ? 2'b01 : (source == fromIr) ? 2'b10 : 2'b00;
        muxBWant = (source == fromMemory) ? 2'b11 : (source == fromIr) ? 2'b10 : 2'b00;
        arfWant = (target == 3'd4) ? 4'b0010 : (target == 3'd5) ? 4'b0100 : 4'b1000;
        if (target < 3'd4) begin
            return bus[15:12] == (4'b0001 << (3 - target)) && bus[9:6] == 4'b0000
                && bus[11:10] == fun && (source == anySource || bus[3:2] == muxAWant);
        end
        return bus[15:12] == 4'b0000 && bus[9:6] == arfWant && bus[5:4] == fun
            && (source == anySource || bus[1:0] == muxBWant);
    endfunction

    function automatic bit readOk(input logic [8:0] bus, input bit useA, input logic [2:0] numA,
                                  input bit useB, input logic [2:0] numB);
        logic [1:0] arfWant;
        bit         ok;
        arfWant = (numA == 3'd4) ? 2'b01 : (numA == 3'd5) ? 2'b00 : 2'b11;
        ok = 1'b1;
        if (useA && numA < 3'd4) begin
            ok = bus[8:6] == 3'b100 + numA && bus[0] == 1'b0;
        end else if (useA) begin
            ok = bus[0] == 1'b1 && bus[2:1] == arfWant;  // Read through the address registers
        end
        if (useB) begin
            ok = ok && bus[5:3] == 3'b100 + numB;
        end
        return ok;
    endfunction

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped on failure");
    endtask

    task automatic reportMismatch(input string message);
        stopWithFailure($sformatf("ERR %0t ns: %s", $time, message));
    endtask

    task automatic nextInstruction();
        logic [15:0] bits;
        takeBits(4, bits);
        irWord.registerFormat.opcode = opcode_t'(bits[3:0] % 4'd14);
        takeBits(12, bits);
        irWord[11:0] = bits[11:0];
        irWord.registerFormat.source2.number[2] = 1'b0;  // Port B stays on R1-R4
        takeBits(4, bits);
        aluFlags = bits[3:0];
    endtask

    // Outputs only settle once the first clock edge has applied reset
    idleOutputs: assert property (@(posedge clock)
        (cycleCount > 0 && (reset || edgeCount == 0 || noRequest))
        |-> (RF_RSel == 4'b0000 && ARF_RegSel == 4'b0000 && !Mem_WR && !IR_Enable))
        else reportMismatch("write enable or strobe active in an idle step");

    fetchStrobes: assert property (@(posedge clock) inFetch
        |-> (IR_Enable && IR_LH == tbStep[0] && ARF_RegSel == 4'b1000 && ARF_FunSel == 2'b11))
        else reportMismatch("fetch strobes or PC increment wrong");

    aluOperation: assert property (@(posedge clock) (inT2 && aluOp)
        |-> (ALU_FunSel == expectedAlu(op) && !Mem_WR
             && readOk(readBus, 1'b1, portA, binaryOp, portB)
             && writeOk(writeBus, dst, 2'b01, fromAlu)))
        else reportMismatch("register ALU operation decoded wrong in T2");

    countCopy: assert property (@(posedge clock) (inT2 && incDec)
        |-> (ALU_FunSel == 4'b0000 && readOk(readBus, 1'b1, src1, 1'b0, 3'd0)
             && writeOk(writeBus, dst, 2'b01, fromAlu)))
        else reportMismatch("INC/DEC copy step wrong");

    countStep: assert property (@(posedge clock) (inT3 && incDec)
        |-> writeOk(writeBus, dst, (op == opInc) ? 2'b11 : 2'b10, anySource))
        else reportMismatch("INC/DEC count step wrong");

    branchLoad: assert property (@(posedge clock) (inT2 && branchTaken)
        |-> writeOk(writeBus, 3'd6, 2'b01, fromIr))
        else reportMismatch("taken branch does not load PC from IR");

    // LD immediate goes straight to the register while LD direct and ST set AR first
    addressLoad: assert property (@(posedge clock) (inT2 && op inside {opLd, opSt})
        |-> writeOk(writeBus, (op == opLd && !direct) ? regSel : 3'd5, 2'b01, fromIr))
        else reportMismatch("LD/ST first step load wrong");

    memoryLoad: assert property (@(posedge clock) (inT3 && op == opLd && direct)
        |-> writeOk(writeBus, regSel, 2'b01, fromMemory))
        else reportMismatch("LD direct does not load the register from memory");

    storeWrite: assert property (@(posedge clock) (inT3 && op == opSt)
        |-> (Mem_WR && ALU_FunSel == 4'b0001 && RF_RSel == 4'b0000 && ARF_RegSel == 4'b0000
             && readOk(readBus, 1'b0, 3'd0, 1'b1, regSel)))
        else reportMismatch("ST memory write step wrong");

    memoryAddress: assert property (@(posedge clock)
        ARF_OutDSel == ((inT3 && op inside {opLd, opSt}) ? 2'b00 : 2'b11))
        else reportMismatch("ARF_OutDSel does not match the step");

    storeOnly: assert property (@(posedge clock) !(inT3 && op == opSt) |-> !Mem_WR)
        else reportMismatch("Mem_WR raised outside ST");

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        irWord = '0;
        aluFlags = 4'b0000;
        lfsrState = 16'd60013;
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;
        for (int n = 0; n < instrCount; n++) begin
            @(posedge clock);  // T0 begins
            #2;
            nextInstruction();
            repeat (3) @(posedge clock);
        end
        repeat (2) @(posedge clock);
        #1;
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- verilog.f
source/isaPkg.sv
source/controlPkg.sv
source/fetchSequencer.sv
source/operandSelect.sv
source/executeDecoder.sv
source/writebackSelect.sv
source/controlUnit.sv
verif/controlUnitTb.sv
